// ==== logic/exe_cfg.svh ====
`ifndef EXE_CFG_SVH
`define EXE_CFG_SVH

// integer datapath width
`define EXE_XLEN 32

// one restoring step per quotient bit
`define EXE_DIV_STEPS `EXE_XLEN

`endif

// ==== logic/exe_op_pkg.sv ====
package exe_op_pkg;

  // opcode as it arrives from issue
  typedef enum logic [4:0] {
    OP_ADD, OP_SUB, OP_SLT, OP_SLTU,
    OP_AND, OP_OR, OP_NOR, OP_XOR,
    OP_SLL, OP_SRL, OP_SRA, OP_LUI,
    OP_MUL, OP_MULH, OP_MULHU,
    OP_DIV, OP_MOD, OP_DIVU, OP_MODU,
    OP_BEQ, OP_BNE, OP_BLT, OP_BGE,
    OP_BLTU, OP_BGEU,
    OP_B, OP_JIRL
  } exe_opcode_e;

  // which unit writes the result
  typedef enum logic [1:0] {
    UNIT_ALU,
    UNIT_DIV,
    UNIT_BRANCH
  } exe_unit_e;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU,
    ALU_AND, ALU_OR, ALU_NOR, ALU_XOR,
    ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI,
    ALU_MUL, ALU_MULH, ALU_MULHU
  } exe_alu_op_e;

  // branch condition, evaluated from less and zero
  typedef enum logic [2:0] {
    BR_NEVER,
    BR_ALWAYS,
    BR_EQ,
    BR_NE,
    BR_LT,
    BR_GE,
    BR_LTU,
    BR_GEU
  } exe_br_cond_e;

endpackage

// ==== logic/exe_bus_pkg.sv ====
`include "exe_cfg.svh"

package exe_bus_pkg;

  localparam int TAG_W = 4;  // in-flight id width

  // request from issue, 138 bits
  typedef struct packed {
    exe_op_pkg::exe_opcode_e opcode;
    logic [`EXE_XLEN-1:0]    src1;
    logic [`EXE_XLEN-1:0]    src2;
    logic [`EXE_XLEN-1:0]    imm;
    logic [`EXE_XLEN-1:0]    pc;
    logic [TAG_W-1:0]        tag;
    logic                    pre_jump;
  } exe_issue_t;

  // decoded word held between decode and execute
  typedef struct packed {
    exe_op_pkg::exe_unit_e    unit;
    exe_op_pkg::exe_alu_op_e  alu_op;
    exe_op_pkg::exe_br_cond_e br_cond;
    logic                     div_signed;
    logic                     div_rem;      // remainder instead of quotient
    logic                     use_rj_base;  // jirl jumps off src1
    logic                     link;         // write back pc+4
    logic [`EXE_XLEN-1:0]     src1;
    logic [`EXE_XLEN-1:0]     src2;
    logic [`EXE_XLEN-1:0]     imm;
    logic [`EXE_XLEN-1:0]     pc;
    logic [TAG_W-1:0]         tag;
    logic                     pre_jump;
  } exe_ctrl_t;

  // record returned to write-back and fetch
  typedef struct packed {
    logic [TAG_W-1:0]     tag;
    logic [`EXE_XLEN-1:0] data;
    logic                 taken;
    logic [`EXE_XLEN-1:0] target;
    logic                 mispredict;
  } exe_result_t;

endpackage

// ==== logic/exe_decode.sv ====
`timescale 1ns/1ps

module exe_decode (
  input  logic                    clk,
  input  logic                    arst_n,
  input  logic                    in_valid,
  output logic                    in_ready,
  input  exe_bus_pkg::exe_issue_t in_req,
  output logic                    dec_valid,
  output exe_bus_pkg::exe_ctrl_t  dec_ctrl,
  input  logic                    dec_ready
);
  import exe_op_pkg::*;
  import exe_bus_pkg::*;

  exe_ctrl_t ctrl_nxt;
  logic      in_fire;

  // free slot, or the held word leaves this cycle
  assign in_ready = ~dec_valid | dec_ready;
  assign in_fire  = in_valid & in_ready;

  always_comb begin
    ctrl_nxt.unit        = UNIT_ALU;
    ctrl_nxt.alu_op      = ALU_ADD;
    ctrl_nxt.br_cond     = BR_NEVER;
    ctrl_nxt.div_signed  = 1'b0;
    ctrl_nxt.div_rem     = 1'b0;
    ctrl_nxt.use_rj_base = 1'b0;
    ctrl_nxt.link        = 1'b0;
    ctrl_nxt.src1        = in_req.src1;
    ctrl_nxt.src2        = in_req.src2;
    ctrl_nxt.imm         = in_req.imm;
    ctrl_nxt.pc          = in_req.pc;
    ctrl_nxt.tag         = in_req.tag;
    ctrl_nxt.pre_jump    = in_req.pre_jump;
    case (in_req.opcode)
      OP_ADD:   ctrl_nxt.alu_op = ALU_ADD;
      OP_SUB:   ctrl_nxt.alu_op = ALU_SUB;
      OP_SLT:   ctrl_nxt.alu_op = ALU_SLT;
      OP_SLTU:  ctrl_nxt.alu_op = ALU_SLTU;
      OP_AND:   ctrl_nxt.alu_op = ALU_AND;
      OP_OR:    ctrl_nxt.alu_op = ALU_OR;
      OP_NOR:   ctrl_nxt.alu_op = ALU_NOR;
      OP_XOR:   ctrl_nxt.alu_op = ALU_XOR;
      OP_SLL:   ctrl_nxt.alu_op = ALU_SLL;
      OP_SRL:   ctrl_nxt.alu_op = ALU_SRL;
      OP_SRA:   ctrl_nxt.alu_op = ALU_SRA;
      OP_LUI:   ctrl_nxt.alu_op = ALU_LUI;
      OP_MUL:   ctrl_nxt.alu_op = ALU_MUL;
      OP_MULH:  ctrl_nxt.alu_op = ALU_MULH;
      OP_MULHU: ctrl_nxt.alu_op = ALU_MULHU;
      OP_DIV, OP_MOD, OP_DIVU, OP_MODU: begin
        ctrl_nxt.unit       = UNIT_DIV;
        ctrl_nxt.div_signed = (in_req.opcode == OP_DIV) | (in_req.opcode == OP_MOD);
        ctrl_nxt.div_rem    = (in_req.opcode == OP_MOD) | (in_req.opcode == OP_MODU);
      end
      // compares run on the alu so less/zero are ready
      OP_BEQ, OP_BNE: begin
        ctrl_nxt.unit    = UNIT_BRANCH;
        ctrl_nxt.alu_op  = ALU_SUB;
        ctrl_nxt.br_cond = (in_req.opcode == OP_BEQ) ? BR_EQ : BR_NE;
      end
      OP_BLT, OP_BGE: begin
        ctrl_nxt.unit    = UNIT_BRANCH;
        ctrl_nxt.alu_op  = ALU_SLT;
        ctrl_nxt.br_cond = (in_req.opcode == OP_BLT) ? BR_LT : BR_GE;
      end
      OP_BLTU, OP_BGEU: begin
        ctrl_nxt.unit    = UNIT_BRANCH;
        ctrl_nxt.alu_op  = ALU_SLTU;
        ctrl_nxt.br_cond = (in_req.opcode == OP_BLTU) ? BR_LTU : BR_GEU;
      end
      OP_B, OP_JIRL: begin
        ctrl_nxt.unit        = UNIT_BRANCH;
        ctrl_nxt.alu_op      = ALU_SUB;
        ctrl_nxt.br_cond     = BR_ALWAYS;
        ctrl_nxt.link        = 1'b1;
        ctrl_nxt.use_rj_base = (in_req.opcode == OP_JIRL);
      end
      default: ctrl_nxt.unit = UNIT_ALU;  // unused encodings act as add
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      dec_valid <= 1'b0;
    end else if (in_fire) begin
      dec_valid <= 1'b1;
    end else if (dec_ready) begin
      dec_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (in_fire) begin
      dec_ctrl <= ctrl_nxt;
    end
  end

endmodule

// ==== logic/exe_alu.sv ====
`timescale 1ns/1ps
`include "exe_cfg.svh"

module exe_alu (
  input  exe_op_pkg::exe_alu_op_e alu_op,
  input  logic [`EXE_XLEN-1:0]    src1,
  input  logic [`EXE_XLEN-1:0]    src2,
  output logic [`EXE_XLEN-1:0]    alu_data,
  output logic                    less,
  output logic                    zero
);
  import exe_op_pkg::*;

  localparam int XLEN = `EXE_XLEN;
  localparam int SH_W = $clog2(XLEN);

  logic                     do_sub;
  logic [XLEN-1:0]          adder_b;
  logic [XLEN-1:0]          adder_res;
  logic                     adder_cout;
  logic                     slt_bit;
  logic                     sltu_bit;
  logic [2*XLEN-1:0]        sr64;
  logic                     mul_signed;
  logic signed [XLEN:0]     mul_a;
  logic signed [XLEN:0]     mul_b;
  logic signed [2*XLEN+1:0] product;

  // one adder for add, sub and both compares
  assign do_sub  = (alu_op == ALU_SUB) | (alu_op == ALU_SLT) | (alu_op == ALU_SLTU);
  assign adder_b = do_sub ? ~src2 : src2;
  assign {adder_cout, adder_res} = src1 + adder_b + {{(XLEN-1){1'b0}}, do_sub};

  // signs differ -> src1 sign decides, else sign of the difference
  assign slt_bit  = (src1[XLEN-1] & ~src2[XLEN-1])
                  | (~(src1[XLEN-1] ^ src2[XLEN-1]) & adder_res[XLEN-1]);
  assign sltu_bit = ~adder_cout;  // borrow out

  // upper half filled with sign for sra only
  assign sr64 = {{XLEN{(alu_op == ALU_SRA) & src1[XLEN-1]}}, src1} >> src2[SH_W-1:0];

  // extra top bit makes one signed multiplier serve both cases
  assign mul_signed = (alu_op == ALU_MULH);
  assign mul_a      = {mul_signed & src1[XLEN-1], src1};
  assign mul_b      = {mul_signed & src2[XLEN-1], src2};
  assign product    = mul_a * mul_b;

  always_comb begin
    case (alu_op)
      ALU_ADD, ALU_SUB: alu_data = adder_res;
      ALU_SLT:          alu_data = {{(XLEN-1){1'b0}}, slt_bit};
      ALU_SLTU:         alu_data = {{(XLEN-1){1'b0}}, sltu_bit};
      ALU_AND:          alu_data = src1 & src2;
      ALU_OR:           alu_data = src1 | src2;
      ALU_NOR:          alu_data = ~(src1 | src2);
      ALU_XOR:          alu_data = src1 ^ src2;
      ALU_SLL:          alu_data = src1 << src2[SH_W-1:0];
      ALU_SRL, ALU_SRA: alu_data = sr64[XLEN-1:0];
      ALU_LUI:          alu_data = src2;  // immediate already shifted upstream
      ALU_MUL:          alu_data = product[XLEN-1:0];
      ALU_MULH, ALU_MULHU: begin
        alu_data = product[2*XLEN-1:XLEN];
      end
      default:          alu_data = adder_res;
    endcase
  end

  // branch flags, meaningful when decode picked sub/slt/sltu
  assign less = (alu_op == ALU_SLTU) ? sltu_bit : slt_bit;
  assign zero = ~|adder_res;

endmodule

// ==== logic/exe_div.sv ====
`timescale 1ns/1ps
`include "exe_cfg.svh"

module exe_div (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 start,
  input  logic                 div_signed,
  input  logic                 div_rem,
  input  logic [`EXE_XLEN-1:0] dividend,
  input  logic [`EXE_XLEN-1:0] divisor,
  output logic                 div_busy,
  output logic                 div_done,
  output logic [`EXE_XLEN-1:0] div_data
);

  localparam int XLEN  = `EXE_XLEN;
  localparam int STEPS = `EXE_DIV_STEPS;
  localparam int CNT_W = $clog2(STEPS);

  typedef enum logic [1:0] {
    IDLE,
    RUN,
    DONE
  } state_e;

  state_e          state;
  logic [CNT_W-1:0] cnt;
  logic [XLEN-1:0] quo;      // dividend bits out, quotient bits in
  logic [XLEN-1:0] rem;
  logic [XLEN-1:0] dvsr;
  logic            neg_q;
  logic            neg_r;
  logic            rem_sel;
  logic            dvsr_zero;
  logic            a_neg;
  logic            b_neg;
  logic [XLEN:0]   rem_sh;
  logic [XLEN:0]   diff;
  logic [XLEN-1:0] quo_fix;
  logic [XLEN-1:0] rem_fix;

  assign a_neg = div_signed & dividend[XLEN-1];
  assign b_neg = div_signed & divisor[XLEN-1];

  // trial subtract, top bit is the borrow
  assign rem_sh = {rem, quo[XLEN-1]};
  assign diff   = rem_sh - {1'b0, dvsr};

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= IDLE;
      cnt   <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (start) begin
            state <= RUN;
            cnt   <= '0;
          end
        end
        RUN: begin
          cnt <= cnt + 1'b1;
          if (cnt == CNT_W'(STEPS - 1)) begin
            state <= DONE;
          end
        end
        DONE:    state <= IDLE;  // done lasts one cycle
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == IDLE && start) begin
      quo       <= a_neg ? -dividend : dividend;
      dvsr      <= b_neg ? -divisor : divisor;
      rem       <= '0;
      neg_q     <= a_neg ^ b_neg;
      neg_r     <= a_neg;  // remainder follows the dividend sign
      rem_sel   <= div_rem;
      dvsr_zero <= ~|divisor;
    end else if (state == RUN) begin
      if (!diff[XLEN]) begin
        rem <= diff[XLEN-1:0];
        quo <= {quo[XLEN-2:0], 1'b1};
      end else begin
        rem <= rem_sh[XLEN-1:0];
        quo <= {quo[XLEN-2:0], 1'b0};
      end
    end
  end

  // zero divisor leaves all ones in quo and |dividend| in rem, so only
  // the quotient sign fix must be skipped
  // min / -1 needs nothing extra: 0x80000000 negates to itself
  assign quo_fix = (neg_q & ~dvsr_zero) ? -quo : quo;
  assign rem_fix = neg_r ? -rem : rem;
  assign div_data = rem_sel ? rem_fix : quo_fix;  // held until next start

  assign div_busy = (state != IDLE);
  assign div_done = (state == DONE);

endmodule

// ==== logic/exe_result.sv ====
`timescale 1ns/1ps
`include "exe_cfg.svh"

module exe_result (
  input  logic                     clk,
  input  logic                     arst_n,
  input  logic                     dec_valid,
  input  exe_bus_pkg::exe_ctrl_t   dec_ctrl,
  output logic                     dec_ready,
  input  logic [`EXE_XLEN-1:0]     alu_data,
  input  logic                     less,
  input  logic                     zero,
  input  logic                     div_busy,
  input  logic                     div_done,
  input  logic [`EXE_XLEN-1:0]     div_data,
  output logic                     div_start,
  output logic                     out_valid,
  output exe_bus_pkg::exe_result_t out_res,
  input  logic                     out_ready
);
  import exe_op_pkg::*;
  import exe_bus_pkg::*;

  localparam int XLEN = `EXE_XLEN;

  logic            is_div;
  logic            is_br;
  logic            div_pend;   // start already sent for this word
  logic            div_ok;     // done seen while output was blocked
  logic            unit_done;
  logic            dec_fire;
  logic            cond_ok;
  logic            taken;
  logic [XLEN-1:0] base;
  logic [XLEN-1:0] target;
  logic [XLEN-1:0] link_data;
  exe_result_t     res_nxt;

  assign is_div    = (dec_ctrl.unit == UNIT_DIV);
  assign is_br     = (dec_ctrl.unit == UNIT_BRANCH);
  assign div_start = dec_valid & is_div & ~div_pend & ~div_busy;
  assign unit_done = ~is_div | div_done | div_ok;
  assign dec_ready = unit_done & (~out_valid | out_ready);
  assign dec_fire  = dec_valid & dec_ready;

  always_comb begin
    case (dec_ctrl.br_cond)
      BR_ALWAYS:      cond_ok = 1'b1;
      BR_EQ:          cond_ok = zero;
      BR_NE:          cond_ok = ~zero;
      BR_LT, BR_LTU:  cond_ok = less;
      BR_GE, BR_GEU:  cond_ok = ~less;
      default:        cond_ok = 1'b0;
    endcase
  end

  assign taken     = is_br & cond_ok;
  assign base      = dec_ctrl.use_rj_base ? dec_ctrl.src1 : dec_ctrl.pc;
  assign target    = base + {dec_ctrl.imm[XLEN-3:0], 2'b00};
  assign link_data = dec_ctrl.pc + XLEN'(4);

  always_comb begin
    res_nxt.tag        = dec_ctrl.tag;
    res_nxt.taken      = taken;
    res_nxt.target     = is_br ? target : '0;
    res_nxt.mispredict = is_br & (taken != dec_ctrl.pre_jump);
    case (dec_ctrl.unit)
      UNIT_DIV:    res_nxt.data = div_data;
      UNIT_BRANCH: res_nxt.data = dec_ctrl.link ? link_data : '0;
      default:     res_nxt.data = alu_data;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      div_pend  <= 1'b0;
      div_ok    <= 1'b0;
      out_valid <= 1'b0;
    end else begin
      if (dec_fire) begin
        div_pend <= 1'b0;
        div_ok   <= 1'b0;
      end else begin
        if (div_start) div_pend <= 1'b1;
        if (div_done)  div_ok   <= 1'b1;
      end
      if (dec_fire) begin
        out_valid <= 1'b1;
      end else if (out_ready) begin
        out_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (dec_fire) begin
      out_res <= res_nxt;  // holds while stalled
    end
  end

endmodule

// ==== logic/exe_top.sv ====
`timescale 1ns/1ps
`include "exe_cfg.svh"

module exe_top (
  input  logic                     clk,
  input  logic                     arst_n,
  input  logic                     in_valid,
  output logic                     in_ready,
  input  exe_bus_pkg::exe_issue_t  in_req,
  output logic                     out_valid,
  input  logic                     out_ready,
  output exe_bus_pkg::exe_result_t out_res
);
  import exe_bus_pkg::*;

  logic                 dec_valid;
  logic                 dec_ready;
  exe_ctrl_t            dec_ctrl;
  logic [`EXE_XLEN-1:0] alu_data;
  logic                 less;
  logic                 zero;
  logic                 div_start;
  logic                 div_busy;
  logic                 div_done;
  logic [`EXE_XLEN-1:0] div_data;

  exe_decode exe_decode_inst (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_req    (in_req),
    .dec_valid (dec_valid),
    .dec_ctrl  (dec_ctrl),
    .dec_ready (dec_ready)
  );

  // branch compare selected by decode via alu_op
  exe_alu exe_alu_inst (
    .alu_op   (dec_ctrl.alu_op),
    .src1     (dec_ctrl.src1),
    .src2     (dec_ctrl.src2),
    .alu_data (alu_data),
    .less     (less),
    .zero     (zero)
  );

  exe_div exe_div_inst (
    .clk        (clk),
    .arst_n     (arst_n),
    .start      (div_start),
    .div_signed (dec_ctrl.div_signed),
    .div_rem    (dec_ctrl.div_rem),
    .dividend   (dec_ctrl.src1),
    .divisor    (dec_ctrl.src2),
    .div_busy   (div_busy),
    .div_done   (div_done),
    .div_data   (div_data)
  );

  exe_result exe_result_inst (
    .clk       (clk),
    .arst_n    (arst_n),
    .dec_valid (dec_valid),
    .dec_ctrl  (dec_ctrl),
    .dec_ready (dec_ready),
    .alu_data  (alu_data),
    .less      (less),
    .zero      (zero),
    .div_busy  (div_busy),
    .div_done  (div_done),
    .div_data  (div_data),
    .div_start (div_start),
    .out_valid (out_valid),
    .out_res   (out_res),
    .out_ready (out_ready)
  );

endmodule

// ==== verification/exe_clk_gen.sv ====
`timescale 1ns/1ps

module exe_clk_gen (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;  // 100 ns period
  end

endmodule

// ==== verification/exe_checker.sv ====
`timescale 1ns/1ps
`include "exe_cfg.svh"

module exe_checker (
  input logic                     clk,
  input logic                     arst_n,
  input logic                     in_valid,
  input logic                     in_ready,
  input exe_bus_pkg::exe_issue_t  in_req,
  input logic                     out_valid,
  input logic                     out_ready,
  input exe_bus_pkg::exe_result_t out_res,
  input logic                     dec_valid,
  input logic                     div_start,
  input logic                     div_done
);

  int fail_cnt = 0;

  // stalled result stays put
  out_hold: assert property (@(posedge clk) disable iff (!arst_n)
      out_valid && !out_ready |=> out_valid && $stable(out_res))
    else begin
      $error("result dropped or changed while out_ready was low");
      fail_cnt++;
    end

  in_hold: assert property (@(posedge clk) disable iff (!arst_n)
      in_valid && !in_ready |=> in_valid && $stable(in_req))
    else begin
      $error("issue request dropped or changed before it was accepted");
      fail_cnt++;
    end

  // full decode behind a stalled result refuses new work
  back_pressure: assert property (@(posedge clk) disable iff (!arst_n)
      out_valid && !out_ready && dec_valid |-> !in_ready)
    else begin
      $error("in_ready high while decode and the stalled output were both full");
      fail_cnt++;
    end

  // fixed divider latency from start to done
  div_latency: assert property (@(posedge clk) disable iff (!arst_n)
      div_start |-> ##(`EXE_DIV_STEPS + 1) div_done)
    else begin
      $error("div_done did not follow div_start after the expected number of cycles");
      fail_cnt++;
    end

  div_to_out: assert property (@(posedge clk) disable iff (!arst_n)
      div_done && (!out_valid || out_ready) |=> out_valid)
    else begin
      $error("div result was not registered on the div_done edge");
      fail_cnt++;
    end

endmodule

bind exe_top exe_checker exe_checker_inst (
  .clk       (clk),
  .arst_n    (arst_n),
  .in_valid  (in_valid),
  .in_ready  (in_ready),
  .in_req    (in_req),
  .out_valid (out_valid),
  .out_ready (out_ready),
  .out_res   (out_res),
  .dec_valid (dec_valid),
  .div_start (div_start),
  .div_done  (div_done)
);

// ==== verification/exe_tb.sv ====
`timescale 1ns/1ps
`include "exe_cfg.svh"

module exe_tb;
  import exe_op_pkg::*;
  import exe_bus_pkg::*;

  localparam int N_RAND    = 80;
  localparam int OP_CYCLES = `EXE_DIV_STEPS + 8;  // a div plus some stall slack

  // one directed entry with stimulus then expected record
  typedef struct packed {
    exe_opcode_e op;
    logic [31:0] src1;
    logic [31:0] src2;
    logic [31:0] imm;
    logic [31:0] pc;
    logic        pre_jump;
    logic [31:0] data;
    logic        taken;
    logic [31:0] target;
    logic        mispredict;
  } vec_t;

  logic        clk;
  logic        arst_n;
  logic        in_valid;
  logic        in_ready;
  exe_issue_t  in_req;
  logic        out_valid;
  logic        out_ready;
  exe_result_t out_res;

  vec_t        table_q[$];
  exe_result_t exp_q[$];      // scoreboard in issue order
  logic        ready_pat [0:255];
  logic [7:0]  pat_idx;
  logic        stall_en;
  logic [3:0]  next_tag;
  int          errors = 0;
  int          n_issued = 0;
  int          n_checked = 0;
  int          cycles = 0;
  int          cycle_limit = 0;

  exe_clk_gen exe_clk_gen_inst (
    .clk (clk)
  );

  exe_top exe_top_inst (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_req    (in_req),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_res   (out_res)
  );

  function automatic void add_vec(exe_opcode_e op, logic [31:0] s1, logic [31:0] s2,
                                  logic [31:0] imm, logic [31:0] pc, logic pj,
                                  logic [31:0] d, logic tk, logic [31:0] tg, logic mp);
    vec_t v;
    v.op         = op;
    v.src1       = s1;
    v.src2       = s2;
    v.imm        = imm;
    v.pc         = pc;
    v.pre_jump   = pj;
    v.data       = d;
    v.taken      = tk;
    v.target     = tg;
    v.mispredict = mp;
    table_q.push_back(v);
  endfunction

  function automatic void load_table();
    add_vec(OP_ADD,   32'h7fffffff, 32'h00000001, 0, 0, 0, 32'h80000000, 0, 0, 0);  // wraps
    add_vec(OP_SUB,   32'h00000000, 32'h00000001, 0, 0, 0, 32'hffffffff, 0, 0, 0);
    add_vec(OP_SLT,   32'hffffffff, 32'h00000001, 0, 0, 0, 32'h00000001, 0, 0, 0);
    add_vec(OP_SLTU,  32'hffffffff, 32'h00000001, 0, 0, 0, 32'h00000000, 0, 0, 0);
    add_vec(OP_AND,   32'hf0f0f0f0, 32'hff00ff00, 0, 0, 0, 32'hf000f000, 0, 0, 0);
    add_vec(OP_OR,    32'hf0f0f0f0, 32'h0f0f0000, 0, 0, 0, 32'hfffff0f0, 0, 0, 0);
    add_vec(OP_NOR,   32'h00000000, 32'h0000ffff, 0, 0, 0, 32'hffff0000, 0, 0, 0);
    add_vec(OP_XOR,   32'haaaaaaaa, 32'hffffffff, 0, 0, 0, 32'h55555555, 0, 0, 0);
    add_vec(OP_SLL,   32'h00000001, 32'h0000003f, 0, 0, 0, 32'h80000000, 0, 0, 0);  // 5 bits
    add_vec(OP_SRL,   32'h80000000, 32'h00000004, 0, 0, 0, 32'h08000000, 0, 0, 0);
    add_vec(OP_SRA,   32'h80000000, 32'h00000004, 0, 0, 0, 32'hf8000000, 0, 0, 0);
    add_vec(OP_LUI,   32'h12345678, 32'habcde000, 0, 0, 0, 32'habcde000, 0, 0, 0);
    add_vec(OP_MUL,   32'hffffffff, 32'hffffffff, 0, 0, 0, 32'h00000001, 0, 0, 0);
    add_vec(OP_MULH,  32'hffffffff, 32'hffffffff, 0, 0, 0, 32'h00000000, 0, 0, 0);
    add_vec(OP_MULHU, 32'hffffffff, 32'hffffffff, 0, 0, 0, 32'hfffffffe, 0, 0, 0);
    add_vec(OP_MULH,  32'h80000000, 32'h80000000, 0, 0, 0, 32'h40000000, 0, 0, 0);
    add_vec(OP_MULH,  32'h80000000, 32'h7fffffff, 0, 0, 0, 32'hc0000000, 0, 0, 0);
    add_vec(OP_DIV,   32'hfffffff9, 32'h00000002, 0, 0, 0, 32'hfffffffd, 0, 0, 0);
    add_vec(OP_MOD,   32'hfffffff9, 32'h00000002, 0, 0, 0, 32'hffffffff, 0, 0, 0);
    add_vec(OP_DIVU,  32'hfffffff9, 32'h00000002, 0, 0, 0, 32'h7ffffffc, 0, 0, 0);
    add_vec(OP_MODU,  32'hfffffff9, 32'h00000002, 0, 0, 0, 32'h00000001, 0, 0, 0);
    add_vec(OP_DIV,   32'h12345678, 32'h00000000, 0, 0, 0, 32'hffffffff, 0, 0, 0);
    add_vec(OP_MOD,   32'h12345678, 32'h00000000, 0, 0, 0, 32'h12345678, 0, 0, 0);
    add_vec(OP_DIV,   32'h80000000, 32'hffffffff, 0, 0, 0, 32'h80000000, 0, 0, 0);
    add_vec(OP_MOD,   32'h80000000, 32'hffffffff, 0, 0, 0, 32'h00000000, 0, 0, 0);
    // branch rows give imm, pc, pre_jump, then data, taken, target and mispredict
    add_vec(OP_BEQ,  32'h5, 32'h5, 32'h4, 32'h1000, 0, 32'h0, 1, 32'h1010, 1);
    add_vec(OP_BNE,  32'h5, 32'h5, 32'h4, 32'h1000, 0, 32'h0, 0, 32'h1010, 0);
    add_vec(OP_BLT,  32'hffffffff, 32'h1, 32'hfffffffe, 32'h2000, 1, 32'h0, 1, 32'h1ff8, 0);
    add_vec(OP_BGE,  32'hffffffff, 32'h1, 32'h2, 32'h2000, 1, 32'h0, 0, 32'h2008, 1);
    add_vec(OP_BLTU, 32'hffffffff, 32'h1, 32'h1, 32'h3000, 0, 32'h0, 0, 32'h3004, 0);
    add_vec(OP_BGEU, 32'hffffffff, 32'h1, 32'h1, 32'h3000, 0, 32'h0, 1, 32'h3004, 1);
    add_vec(OP_B,    32'h0, 32'h0, 32'h100, 32'h4000, 1, 32'h4004, 1, 32'h4400, 0);
    add_vec(OP_JIRL, 32'h8000, 32'h0, 32'h3, 32'h5000, 0, 32'h5004, 1, 32'h800c, 1);
  endfunction

  function automatic exe_issue_t make_req(exe_opcode_e op, logic [31:0] s1, logic [31:0] s2,
                                          logic [31:0] imm, logic [31:0] pc, logic pj);
    exe_issue_t r;
    r          = '0;
    r.opcode   = op;
    r.src1     = s1;
    r.src2     = s2;
    r.imm      = imm;
    r.pc       = pc;
    r.pre_jump = pj;
    return r;
  endfunction

  function automatic logic [31:0] div_model(exe_opcode_e op, logic [31:0] a, logic [31:0] b);
    logic        sgn;
    logic [31:0] q;
    logic [31:0] rm;
    sgn = (op == OP_DIV) || (op == OP_MOD);
    if (b == 32'h0) begin
      q  = 32'hffffffff;
      rm = a;
    end else if (sgn && a == 32'h80000000 && b == 32'hffffffff) begin
      q  = a;
      rm = 32'h0;
    end else if (sgn) begin
      q  = $signed(a) / $signed(b);  // truncates toward zero
      rm = $signed(a) % $signed(b);
    end else begin
      q  = a / b;
      rm = a % b;
    end
    return ((op == OP_MOD) || (op == OP_MODU)) ? rm : q;
  endfunction

  // expected record straight from the arithmetic and branch rules
  function automatic exe_result_t model(exe_issue_t r);
    exe_result_t e;
    logic [63:0] prod;
    logic [31:0] base;
    logic        cond;
    e     = '0;
    e.tag = r.tag;
    cond  = 1'b1;  // b and jirl
    case (r.opcode)
      OP_ADD:  e.data = r.src1 + r.src2;
      OP_SUB:  e.data = r.src1 - r.src2;
      OP_SLT:  e.data = ($signed(r.src1) < $signed(r.src2)) ? 32'd1 : 32'd0;
      OP_SLTU: e.data = (r.src1 < r.src2) ? 32'd1 : 32'd0;
      OP_AND:  e.data = r.src1 & r.src2;
      OP_OR:   e.data = r.src1 | r.src2;
      OP_NOR:  e.data = ~(r.src1 | r.src2);
      OP_XOR:  e.data = r.src1 ^ r.src2;
      OP_SLL:  e.data = r.src1 << r.src2[4:0];
      OP_SRL:  e.data = r.src1 >> r.src2[4:0];
      OP_SRA:  e.data = $signed(r.src1) >>> r.src2[4:0];
      OP_LUI:  e.data = r.src2;
      OP_MUL, OP_MULHU: begin
        prod   = {32'h0, r.src1} * {32'h0, r.src2};
        e.data = (r.opcode == OP_MUL) ? prod[31:0] : prod[63:32];
      end
      OP_MULH: begin
        prod   = {{32{r.src1[31]}}, r.src1} * {{32{r.src2[31]}}, r.src2};
        e.data = prod[63:32];
      end
      OP_DIV, OP_MOD, OP_DIVU, OP_MODU: e.data = div_model(r.opcode, r.src1, r.src2);
      OP_BEQ:  cond = (r.src1 == r.src2);
      OP_BNE:  cond = (r.src1 != r.src2);
      OP_BLT:  cond = ($signed(r.src1) < $signed(r.src2));
      OP_BGE:  cond = ($signed(r.src1) >= $signed(r.src2));
      OP_BLTU: cond = (r.src1 < r.src2);
      OP_BGEU: cond = (r.src1 >= r.src2);
      default: e.data = 32'h0;
    endcase
    if (r.opcode >= OP_BEQ) begin
      base         = (r.opcode == OP_JIRL) ? r.src1 : r.pc;
      e.taken      = cond;
      e.target     = base + (r.imm << 2);
      e.mispredict = (cond != r.pre_jump);
      e.data       = (r.opcode == OP_B || r.opcode == OP_JIRL) ? r.pc + 32'd4 : 32'h0;
    end
    return e;
  endfunction

  function automatic logic [31:0] pick_operand();
    case ($urandom % 8)
      0:       return 32'h0;
      1:       return 32'hffffffff;
      2:       return 32'h80000000;
      3:       return 32'h7fffffff;
      4:       return $urandom % 16;
      default: return $urandom;
    endcase
  endfunction

  function automatic exe_issue_t random_req();
    exe_issue_t r;
    r = '0;
    if ($urandom % 3 == 0) begin
      r.opcode = exe_opcode_e'($urandom_range(int'(OP_DIV), int'(OP_MODU)));  // more divs
    end else begin
      r.opcode = exe_opcode_e'($urandom_range(0, int'(OP_JIRL)));
    end
    r.src1     = pick_operand();
    r.src2     = pick_operand();
    r.imm      = $urandom;
    r.pc       = $urandom & 32'hfffffffc;
    r.pre_jump = $urandom % 2;
    return r;
  endfunction

  function automatic bit check_field(string name, logic [31:0] expv, logic [31:0] gotv);
    assert (gotv === expv) else begin
      $display("[FAIL] %0t ns out_res.%s: expected %h, got %h", $time, name, expv, gotv);
      errors++;
    end
    return (gotv === expv);
  endfunction

  // drive on the falling edge and return on the accepting rising edge
  task automatic issue(input exe_issue_t req, input exe_result_t expv);
    @(negedge clk);
    req.tag  = next_tag;
    expv.tag = next_tag;
    next_tag = next_tag + 4'd1;
    in_req   = req;
    in_valid = 1'b1;
    exp_q.push_back(expv);
    n_issued++;
    do begin
      @(posedge clk);
    end while (!in_ready);
  endtask

  task automatic drain();
    while (exp_q.size() != 0) @(negedge clk);
    @(negedge clk);
  endtask

  // accepted on edge N and visible after N+1
  task automatic check_latency();
    exe_issue_t req;
    bit         ok;
    ok  = 1'b1;
    req = make_req(OP_ADD, 32'd3, 32'd4, 32'd0, 32'd0, 1'b0);
    issue(req, model(req));
    @(negedge clk);
    in_valid = 1'b0;
    assert (!out_valid) else begin
      $display("[FAIL] %0t ns out_valid: expected 0, got %b", $time, out_valid);
      errors++;
      ok = 1'b0;
    end
    @(negedge clk);
    assert (out_valid) else begin
      $display("[FAIL] %0t ns out_valid: expected 1, got %b", $time, out_valid);
      errors++;
      ok = 1'b0;
    end
    $display("%s latency of an add with out_ready high", ok ? "[ok]  " : "[bad] ");
  endtask

  always @(negedge clk) begin
    out_ready = stall_en ? ready_pat[pat_idx] : 1'b1;
    pat_idx   = pat_idx + 8'd1;
  end

  // scoreboard sampled on the transfer edge
  always @(posedge clk) begin
    exe_result_t expv;
    bit          ok;
    if (arst_n && out_valid && out_ready) begin
      assert (exp_q.size() != 0) else begin
        $display("result with tag %0d arrived while nothing was outstanding", out_res.tag);
        errors++;
      end
      if (exp_q.size() != 0) begin
        expv = exp_q.pop_front();
        ok   = check_field("tag", 32'(expv.tag), 32'(out_res.tag));
        ok   = check_field("data", expv.data, out_res.data) && ok;
        ok   = check_field("taken", 32'(expv.taken), 32'(out_res.taken)) && ok;
        ok   = check_field("target", expv.target, out_res.target) && ok;
        ok   = check_field("mispredict", 32'(expv.mispredict), 32'(out_res.mispredict)) && ok;
        n_checked++;
        $display("%s result %0d tag %0d", ok ? "[ok]  " : "[bad] ", n_checked, out_res.tag);
      end
    end
  end

  initial begin
    @(posedge arst_n);
    while (cycles < cycle_limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout after %0d cycles, %0d results still outstanding", cycles, exp_q.size());
    $display("Testbench failed");
    $finish;
  end

  initial begin
    exe_issue_t  req;
    exe_result_t expv;
    arst_n   = 1'b0;
    in_valid = 1'b0;
    in_req   = '0;
    out_ready = 1'b1;
    stall_en = 1'b0;
    pat_idx  = 8'd0;
    next_tag = 4'd0;
    void'($urandom(32'hac74cdf0));
    foreach (ready_pat[i]) ready_pat[i] = (($urandom % 4) != 0);  // high 3 of 4
    load_table();
    cycle_limit = (table_q.size() + 1 + N_RAND) * OP_CYCLES + 100;
    repeat (5) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;

    foreach (table_q[i]) begin
      req = make_req(table_q[i].op, table_q[i].src1, table_q[i].src2,
                     table_q[i].imm, table_q[i].pc, table_q[i].pre_jump);
      expv            = '0;
      expv.data       = table_q[i].data;
      expv.taken      = table_q[i].taken;
      expv.target     = table_q[i].target;
      expv.mispredict = table_q[i].mispredict;
      issue(req, expv);
    end
    @(negedge clk);
    in_valid = 1'b0;
    drain();
    check_latency();
    drain();

    stall_en = 1'b1;  // random stalls with issues packed behind divs
    for (int i = 0; i < N_RAND; i++) begin
      req = random_req();
      issue(req, model(req));
      if ($urandom % 4 == 0) begin
        @(negedge clk);
        in_valid = 1'b0;
      end
    end
    @(negedge clk);
    in_valid = 1'b0;
    drain();
    stall_en = 1'b0;
    repeat (2) @(negedge clk);

    errors += exe_top_inst.exe_checker_inst.fail_cnt;
    $display("summary: %0d issued, %0d results checked, %0d errors",
             n_issued, n_checked, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// ==== flist.f ====
+incdir+logic
logic/exe_op_pkg.sv
logic/exe_bus_pkg.sv
logic/exe_decode.sv
logic/exe_alu.sv
logic/exe_div.sv
logic/exe_result.sv
logic/exe_top.sv
verification/exe_clk_gen.sv
verification/exe_checker.sv
verification/exe_tb.sv
